// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - logic/rv_isa_pkg.sv
  - logic/frontend_pkg.sv
  - logic/inst_compact.sv
  - logic/block_gen.sv
  - logic/ftq.sv
  - logic/fetch_pipe.sv
  - logic/fetcher.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/fetch_tb.sv

// ==== flist.f ====
+incdir+verif
logic/rv_isa_pkg.sv
logic/frontend_pkg.sv
logic/inst_compact.sv
logic/block_gen.sv
logic/ftq.sv
logic/fetch_pipe.sv
logic/fetcher.sv
verif/fetch_tb.sv

// ==== logic/block_gen.sv ====
`timescale 1ns/100ps

module block_gen (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    i_squash_vld,
    input  frontend_pkg::addr_t     i_squash_pc,

    input  logic                    i_ftq_rdy,
    output logic                    o_blk_vld,
    output frontend_pkg::addr_t     o_blk_start,
    output frontend_pkg::blk_size_t o_blk_size
);

    import frontend_pkg::*;

    addr_t pc;
    logic  vld_q;

    // block ends at the next 16-byte boundary
    assign o_blk_size = blk_size_t'(BLOCK_BYTES) - blk_size_t'(pc[BLOCK_OFF_BITS-1:0]);
    assign o_blk_start = pc;
    assign o_blk_vld = vld_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
            vld_q <= 1'b0;
        end else begin
            vld_q <= 1'b1;
            // squash wins over a block accepted in the same cycle
            if (i_squash_vld) begin
                pc <= i_squash_pc;
            end else if (vld_q && i_ftq_rdy) begin
                pc <= pc + addr_t'(o_blk_size);
            end
        end
    end

    a_blk_size_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        o_blk_vld |-> (o_blk_size != '0)
    ) else $error("block_gen: zero sized block at %h", o_blk_start);

endmodule

// ==== logic/fetch_pipe.sv ====
`timescale 1ns/100ps

module fetch_pipe (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   i_squash_vld,
    input  logic                                   i_backend_stall,

    input  logic                                   i_fetch_req,
    input  frontend_pkg::ftq_idx_t                 i_fetch_idx,
    input  frontend_pkg::addr_t                    i_fetch_start,
    input  frontend_pkg::blk_size_t                i_fetch_size,
    output logic                                   o_req_rdy,

    output logic                                   o_icache_req,
    output frontend_pkg::line_addr_t               o_icache_addr,
    output logic                                   o_icache_get2,
    input  logic                                   i_icache_gnt,
    input  logic                                   i_icache_rsp,
    input  logic [frontend_pkg::LINE_BYTES*8-1:0]  i_icache_line0,
    input  logic [frontend_pkg::LINE_BYTES*8-1:0]  i_icache_line1,

    output frontend_pkg::ftq_idx_t                 o_recover_idx,

    output logic [frontend_pkg::FETCH_WIDTH-1:0]   o_fetch_inst_vld,
    output rv_isa_pkg::inst_t                      o_fetch_inst [frontend_pkg::FETCH_WIDTH],
    output frontend_pkg::ftq_idx_t                 o_fetch_idx_out,
    output frontend_pkg::blk_off_t                 o_fetch_off [frontend_pkg::FETCH_WIDTH],
    output logic                                   o_fetch_exc
);

    import rv_isa_pkg::*;
    import frontend_pkg::*;

    logic misalign;
    logic issue;
    logic exc_go;

    // acc tracks cache accesses, vld tracks live items
    logic                     s1_acc;
    logic                     s1_vld;
    logic                     s1_exc;
    ftq_idx_t                 s1_idx;
    logic [LINE_OFF_BITS-1:0] s1_off;
    blk_size_t                s1_size;

    logic                     s2_acc;
    logic                     s2_vld;
    ftq_idx_t                 s2_idx;
    logic [LINE_OFF_BITS-1:0] s2_shift;
    blk_size_t                s2_size;

    logic [2*LINE_BYTES*8-1:0] merged;
    logic [FETCH_WIDTH-1:0]    slot_vld;
    inst_t                     slot_inst [FETCH_WIDTH];
    blk_off_t                  slot_off [FETCH_WIDTH];
    logic [FETCH_WIDTH-1:0]    comp_vld;
    inst_t                     comp_inst [FETCH_WIDTH];
    blk_off_t                  comp_off [FETCH_WIDTH];

    // odd start skips the cache
    assign misalign = i_fetch_start[0];
    assign o_icache_req = i_fetch_req && !misalign && !i_backend_stall;
    assign o_icache_addr = i_fetch_start[XLEN-1:LINE_OFF_BITS];
    assign o_icache_get2 = i_fetch_start[LINE_OFF_BITS-1];
    // exception entry must not collide with a line leaving stage 2
    assign o_req_rdy = !i_backend_stall && (misalign ? !s1_vld : i_icache_gnt);
    assign issue = i_fetch_req && o_req_rdy;
    assign exc_go = s1_vld && s1_exc;

    assign o_recover_idx = s2_vld ? s2_idx : (s1_vld ? s1_idx : i_fetch_idx);

    assign merged = {i_icache_line1, i_icache_line0} >> {s2_shift, 3'b000};

    // predecode, a slot after a 32-bit opener is its upper half
    always_comb begin
        logic prev32;

        prev32 = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slot_inst[i] = merged[i*16 +: ILEN];
            slot_off[i] = blk_off_t'(2 * i);
            slot_vld[i] = !prev32 && ((2 * i) < s2_size);
            prev32 = !prev32 && (slot_inst[i][1:0] == OP_LEN32);
        end
    end

    inst_compact #(.W(ILEN)) u_compact_inst (
        .i_vld  ( slot_vld  ),
        .i_data ( slot_inst ),
        .o_vld  ( comp_vld  ),
        .o_data ( comp_inst )
    );

    inst_compact #(.W(BLOCK_OFF_BITS)) u_compact_off (
        .i_vld  ( slot_vld ),
        .i_data ( slot_off ),
        .o_vld  (          ),
        .o_data ( comp_off )
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_acc <= 1'b0;
            s1_vld <= 1'b0;
            s2_acc <= 1'b0;
            s2_vld <= 1'b0;
            o_fetch_inst_vld <= '0;
            o_fetch_exc <= 1'b0;
        end else begin
            s1_acc <= issue && !misalign;
            s1_vld <= issue && !i_squash_vld;
            s2_acc <= s1_acc;
            s2_vld <= s1_vld && !s1_exc && !i_backend_stall && !i_squash_vld;
            if (i_squash_vld) begin
                o_fetch_inst_vld <= '0;
                o_fetch_exc <= 1'b0;
            end else if (!i_backend_stall) begin
                if (exc_go) begin
                    o_fetch_inst_vld <= {{(FETCH_WIDTH-1){1'b0}}, 1'b1};
                end else if (s2_vld && i_icache_rsp) begin
                    o_fetch_inst_vld <= comp_vld;
                end else begin
                    o_fetch_inst_vld <= '0;
                end
                o_fetch_exc <= exc_go;
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_exc <= misalign;
        s1_idx <= i_fetch_idx;
        s1_off <= i_fetch_start[LINE_OFF_BITS-1:0];
        s1_size <= i_fetch_size;
        s2_idx <= s1_idx;
        s2_shift <= s1_off;
        s2_size <= s1_size;
        // output held while the backend stalls
        if (!i_backend_stall) begin
            o_fetch_idx_out <= exc_go ? s1_idx : s2_idx;
            o_fetch_inst <= comp_inst;
            for (int k = 0; k < FETCH_WIDTH; k++) begin
                o_fetch_off[k] <= exc_go ? blk_off_t'(0) : comp_off[k];
            end
        end
    end

    a_rsp_in_stage2: assert property (
        @(posedge clk) disable iff (rst)
        i_icache_rsp |-> s2_acc
    ) else $error("fetch_pipe: cache response with no access in stage 2");

endmodule

// ==== logic/fetcher.sv ====
`timescale 1ns/100ps

module fetcher (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   i_squash_vld,
    input  frontend_pkg::addr_t                    i_squash_pc,
    input  logic                                   i_backend_stall,
    input  logic                                   i_commit_vld,
    input  frontend_pkg::ftq_idx_t                 i_commit_idx,

    input  frontend_pkg::ftq_idx_t                 i_read_idx,
    output frontend_pkg::addr_t                    o_read_start,
    output frontend_pkg::addr_t                    o_read_next,

    output logic                                   o_icache_req,
    output frontend_pkg::line_addr_t               o_icache_addr,
    output logic                                   o_icache_get2,
    input  logic                                   i_icache_gnt,
    input  logic                                   i_icache_rsp,
    input  logic [frontend_pkg::LINE_BYTES*8-1:0]  i_icache_line0,
    input  logic [frontend_pkg::LINE_BYTES*8-1:0]  i_icache_line1,

    output logic [frontend_pkg::FETCH_WIDTH-1:0]   o_fetch_inst_vld,
    output rv_isa_pkg::inst_t                      o_fetch_inst [frontend_pkg::FETCH_WIDTH],
    output frontend_pkg::ftq_idx_t                 o_fetch_idx_out,
    output frontend_pkg::blk_off_t                 o_fetch_off [frontend_pkg::FETCH_WIDTH],
    output logic                                   o_fetch_exc
);

    import frontend_pkg::*;

    logic      blk_vld;
    addr_t     blk_start;
    blk_size_t blk_size;
    logic      ftq_rdy;

    logic      fetch_req;
    ftq_idx_t  fetch_idx;
    addr_t     fetch_start;
    blk_size_t fetch_size;
    logic      req_rdy;
    ftq_idx_t  recover_idx;

    block_gen u_block_gen (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .i_squash_vld ( i_squash_vld ),
        .i_squash_pc  ( i_squash_pc  ),
        .i_ftq_rdy    ( ftq_rdy      ),
        .o_blk_vld    ( blk_vld      ),
        .o_blk_start  ( blk_start    ),
        .o_blk_size   ( blk_size     )
    );

    ftq u_ftq (
        .clk           ( clk             ),
        .rst           ( rst             ),
        .i_squash_vld  ( i_squash_vld    ),
        .i_stall       ( i_backend_stall ),
        .i_recover_idx ( recover_idx     ),
        .i_blk_vld     ( blk_vld         ),
        .i_blk_start   ( blk_start       ),
        .i_blk_size    ( blk_size        ),
        .o_ftq_rdy     ( ftq_rdy         ),
        .o_fetch_req   ( fetch_req       ),
        .o_fetch_idx   ( fetch_idx       ),
        .o_fetch_start ( fetch_start     ),
        .o_fetch_size  ( fetch_size      ),
        .i_req_rdy     ( req_rdy         ),
        .i_commit_vld  ( i_commit_vld    ),
        .i_commit_idx  ( i_commit_idx    ),
        .i_read_idx    ( i_read_idx      ),
        .o_read_start  ( o_read_start    ),
        .o_read_next   ( o_read_next     )
    );

    fetch_pipe u_fetch_pipe (
        .clk              ( clk              ),
        .rst              ( rst              ),
        .i_squash_vld     ( i_squash_vld     ),
        .i_backend_stall  ( i_backend_stall  ),
        .i_fetch_req      ( fetch_req        ),
        .i_fetch_idx      ( fetch_idx        ),
        .i_fetch_start    ( fetch_start      ),
        .i_fetch_size     ( fetch_size       ),
        .o_req_rdy        ( req_rdy          ),
        .o_icache_req     ( o_icache_req     ),
        .o_icache_addr    ( o_icache_addr    ),
        .o_icache_get2    ( o_icache_get2    ),
        .i_icache_gnt     ( i_icache_gnt     ),
        .i_icache_rsp     ( i_icache_rsp     ),
        .i_icache_line0   ( i_icache_line0   ),
        .i_icache_line1   ( i_icache_line1   ),
        .o_recover_idx    ( recover_idx      ),
        .o_fetch_inst_vld ( o_fetch_inst_vld ),
        .o_fetch_inst     ( o_fetch_inst     ),
        .o_fetch_idx_out  ( o_fetch_idx_out  ),
        .o_fetch_off      ( o_fetch_off      ),
        .o_fetch_exc      ( o_fetch_exc      )
    );

endmodule

// ==== logic/frontend_pkg.sv ====
package frontend_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;

    // cache line and fetch block geometry, in bytes
    localparam int LINE_BYTES = 32;
    localparam int BLOCK_BYTES = 16;
    localparam int LINE_OFF_BITS = $clog2(LINE_BYTES);
    localparam int BLOCK_OFF_BITS = $clog2(BLOCK_BYTES);

    // halfword slots in one block
    localparam int FETCH_WIDTH = BLOCK_BYTES / 2;

    localparam int FTQ_DEPTH = 8;

    typedef logic [$clog2(FTQ_DEPTH)-1:0] ftq_idx_t;

    // byte offset of an instruction from its block start
    typedef logic [BLOCK_OFF_BITS-1:0] blk_off_t;

    // 1 to 16 bytes
    typedef logic [BLOCK_OFF_BITS:0] blk_size_t;

    typedef logic [XLEN-LINE_OFF_BITS-1:0] line_addr_t;

    localparam addr_t RESET_PC = 32'h8000_0000;

endpackage

// ==== logic/ftq.sv ====
`timescale 1ns/100ps

module ftq (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_squash_vld,
    input  logic                    i_stall,
    input  frontend_pkg::ftq_idx_t  i_recover_idx,

    input  logic                    i_blk_vld,
    input  frontend_pkg::addr_t     i_blk_start,
    input  frontend_pkg::blk_size_t i_blk_size,
    output logic                    o_ftq_rdy,

    output logic                    o_fetch_req,
    output frontend_pkg::ftq_idx_t  o_fetch_idx,
    output frontend_pkg::addr_t     o_fetch_start,
    output frontend_pkg::blk_size_t o_fetch_size,
    input  logic                    i_req_rdy,

    input  logic                    i_commit_vld,
    input  frontend_pkg::ftq_idx_t  i_commit_idx,

    input  frontend_pkg::ftq_idx_t  i_read_idx,
    output frontend_pkg::addr_t     o_read_start,
    output frontend_pkg::addr_t     o_read_next
);

    import frontend_pkg::*;

    typedef enum logic {
        RUN,
        REWIND
    } ftq_state_t;

    addr_t     start_q [FTQ_DEPTH];
    blk_size_t size_q [FTQ_DEPTH];

    ftq_state_t state;

    // one extra bit tells full from empty
    logic [$bits(ftq_idx_t):0] alloc_ptr;
    logic [$bits(ftq_idx_t):0] fetch_ptr;
    logic [$bits(ftq_idx_t):0] commit_ptr;
    logic [$bits(ftq_idx_t):0] commit_nxt;
    logic [$bits(ftq_idx_t):0] used;

    ftq_idx_t commit_dist;
    ftq_idx_t rewind_dist;
    logic     full;
    logic     alloc;
    logic     advance;

    assign used = alloc_ptr - commit_ptr;
    assign full = (used == FTQ_DEPTH);
    assign o_ftq_rdy = !full;
    assign alloc = i_blk_vld && !full && !i_squash_vld;

    assign o_fetch_req = (state == RUN) && (fetch_ptr != alloc_ptr);
    assign o_fetch_idx = fetch_ptr[$bits(ftq_idx_t)-1:0];
    assign o_fetch_start = start_q[o_fetch_idx];
    assign o_fetch_size = size_q[o_fetch_idx];
    assign advance = o_fetch_req && i_req_rdy;

    // commit frees everything up to and including the index
    assign commit_dist = i_commit_idx - commit_ptr[$bits(ftq_idx_t)-1:0];
    assign commit_nxt = i_commit_vld ? commit_ptr + {1'b0, commit_dist} + 1'b1 : commit_ptr;

    // how far the fetch pointer steps back on a stall
    assign rewind_dist = o_fetch_idx - i_recover_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_ptr <= '0;
            fetch_ptr <= '0;
            commit_ptr <= '0;
            state <= RUN;
        end else begin
            commit_ptr <= commit_nxt;
            if (i_squash_vld) begin
                alloc_ptr <= commit_nxt;
                fetch_ptr <= commit_nxt;
                state <= RUN;
            end else begin
                if (alloc) begin
                    alloc_ptr <= alloc_ptr + 1'b1;
                end
                case (state)
                    RUN: begin
                        if (i_stall) begin
                            fetch_ptr <= fetch_ptr - {1'b0, rewind_dist};
                            state <= REWIND;
                        end else if (advance) begin
                            fetch_ptr <= fetch_ptr + 1'b1;
                        end
                    end
                    default: state <= RUN;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            start_q[alloc_ptr[$bits(ftq_idx_t)-1:0]] <= i_blk_start;
            size_q[alloc_ptr[$bits(ftq_idx_t)-1:0]] <= i_blk_size;
        end
    end

    assign o_read_start = start_q[i_read_idx];
    assign o_read_next = start_q[i_read_idx] + addr_t'(size_q[i_read_idx]);

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        used <= FTQ_DEPTH
    ) else $error("ftq: more entries than FTQ_DEPTH");

    a_commit_fetched: assert property (
        @(posedge clk) disable iff (rst)
        i_commit_vld |-> ({1'b0, commit_dist} < (fetch_ptr - commit_ptr))
    ) else $error("ftq: commit of index %0d not yet fetched", i_commit_idx);

endmodule

// ==== logic/inst_compact.sv ====
`timescale 1ns/100ps

module inst_compact #(
    parameter int W = 32
) (
    input  logic [frontend_pkg::FETCH_WIDTH-1:0] i_vld,
    input  logic [W-1:0]                         i_data [frontend_pkg::FETCH_WIDTH],
    output logic [frontend_pkg::FETCH_WIDTH-1:0] o_vld,
    output logic [W-1:0]                         o_data [frontend_pkg::FETCH_WIDTH]
);

    import frontend_pkg::*;

    always_comb begin
        logic [$clog2(FETCH_WIDTH):0] cnt;

        cnt = '0;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            o_data[k] = '0;
        end
        // k-th valid input lands in slot k
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (i_vld[i]) begin
                o_data[cnt[$clog2(FETCH_WIDTH)-1:0]] = i_data[i];
                cnt = cnt + 1'b1;
            end
        end
        // thermometer of the count
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            o_vld[k] = (k < cnt);
        end
    end

endmodule

// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // instruction word and the 16-bit parcel
    localparam int ILEN = 32;
    localparam int PARCEL_BITS = 16;

    typedef logic [ILEN-1:0] inst_t;
    typedef logic [PARCEL_BITS-1:0] half_t;

    // low two bits of a parcel that open a 32-bit instruction
    localparam logic [1:0] OP_LEN32 = 2'b11;

    // exception codes carried with a fetched entry
    typedef logic [3:0] exc_code_t;

    localparam exc_code_t exc_pc_misaligned = 4'd0;
    localparam exc_code_t exc_fetch_fault = 4'd1;
    localparam exc_code_t exc_illegal_inst = 4'd2;

endpackage

// ==== verif/fetch_tb_model.svh ====
`ifndef FETCH_TB_MODEL_SVH
`define FETCH_TB_MODEL_SVH

localparam int IMEM_BYTES = 4096;

logic [31:0] lfsr = 32'h3759_8cdf;
logic [7:0]  imem [IMEM_BYTES];
int          errors = 0;
int          checks = 0;

// taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;

    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_step(lfsr);
        v = {v[30:0], lfsr[0]};
    end
endtask

task automatic fill_image();
    logic [31:0] r;

    for (int i = 0; i < IMEM_BYTES; i++) begin
        take_bits(8, r);
        imem[i] = r[7:0];
    end
endtask

// outside the image every byte is a hash of its address
function automatic logic [7:0] mem_byte(input addr_t a);
    addr_t      rel;
    logic [7:0] b;

    rel = a - RESET_PC;
    if (rel < IMEM_BYTES) begin
        b = imem[rel[11:0]];
    end else begin
        b = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    end
    // last parcel of a block never opens a 32-bit instruction
    if (a[3:0] == 4'he) begin
        b[0] = 1'b0;
    end
    return b;
endfunction

function automatic logic [31:0] mem_word(input addr_t a);
    return {mem_byte(a + 3), mem_byte(a + 2), mem_byte(a + 1), mem_byte(a)};
endfunction

function automatic logic [LINE_BYTES*8-1:0] line_data(input line_addr_t la);
    logic [LINE_BYTES*8-1:0] d;

    for (int b = 0; b < LINE_BYTES; b++) begin
        d[b*8 +: 8] = mem_byte({la, 5'b00000} + addr_t'(b));
    end
    return d;
endfunction

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

`endif

// ==== verif/fetch_tb.sv ====
`timescale 1ns/100ps

module fetch_tb;

    import rv_isa_pkg::*;
    import frontend_pkg::*;

    `include "fetch_tb_model.svh"

    logic                   clk = 1'b0;
    logic                   rst = 1'b1;
    logic                   i_squash_vld = 1'b0;
    addr_t                  i_squash_pc = '0;
    logic                   i_backend_stall = 1'b0;
    logic                   i_commit_vld = 1'b0;
    ftq_idx_t               i_commit_idx = '0;
    ftq_idx_t               i_read_idx = '0;
    logic                   i_icache_gnt = 1'b0;
    logic                   i_icache_rsp = 1'b0;
    logic [LINE_BYTES*8-1:0] i_icache_line0 = '0;
    logic [LINE_BYTES*8-1:0] i_icache_line1 = '0;

    addr_t                  o_read_start;
    addr_t                  o_read_next;
    logic                   o_icache_req;
    line_addr_t             o_icache_addr;
    logic                   o_icache_get2;
    logic [FETCH_WIDTH-1:0] o_fetch_inst_vld;
    inst_t                  o_fetch_inst [FETCH_WIDTH];
    ftq_idx_t               o_fetch_idx_out;
    blk_off_t               o_fetch_off [FETCH_WIDTH];
    logic                   o_fetch_exc;

    // reference model state
    addr_t    exp_pc = RESET_PC;
    ftq_idx_t exp_idx = '0;
    ftq_idx_t commit_next_idx = '0;
    int       blocks_done = 0;
    int       cycle = 0;
    ftq_idx_t seen_idx [$];
    addr_t    seen_start [$];
    addr_t    seen_size [$];
    int       req_cycles [$];

    // knobs and next-cycle inputs
    logic     gnt_always = 1'b0;
    logic     stall_on = 1'b0;
    logic     commit_on = 1'b1;
    logic     timing_on = 1'b0;
    logic     squash_pending = 1'b0;
    addr_t    squash_target = '0;
    logic     nxt_gnt = 1'b0;
    logic     nxt_stall = 1'b0;
    logic     nxt_squash = 1'b0;
    addr_t    nxt_squash_pc = '0;
    logic     nxt_commit_vld = 1'b0;
    ftq_idx_t nxt_commit_idx = '0;
    ftq_idx_t nxt_read_idx = '0;
    logic     rd_chk = 1'b0;
    addr_t    rd_start = '0;
    addr_t    rd_next = '0;
    logic     prev_stall = 1'b0;
    logic     prev_squash = 1'b0;

    // cache model, two-deep response delay
    logic       d1_vld = 1'b0;
    logic       d2_vld = 1'b0;
    line_addr_t d1_addr = '0;
    line_addr_t d2_addr = '0;
    logic       d1_get2 = 1'b0;
    logic       d2_get2 = 1'b0;
    logic       rsp_get2 = 1'b0;
    // get2 of the request behind the current output beat
    logic       beat_get2 = 1'b0;

    logic [FETCH_WIDTH-1:0] snap_vld;
    ftq_idx_t               snap_idx;
    logic                   snap_exc;
    inst_t                  snap_inst [FETCH_WIDTH];
    blk_off_t               snap_off [FETCH_WIDTH];

    always #20 clk = !clk;

    fetcher uut (.*);

    task automatic abort_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic check_beat();
        addr_t size;
        int    n;
        int    off;
        inst_t w;

        size = 16 - exp_pc[3:0];
        check_value("o_fetch_idx_out", o_fetch_idx_out, exp_idx);
        if (exp_pc[0]) begin
            check_value("o_fetch_exc", o_fetch_exc, 1);
            check_value("o_fetch_inst_vld", o_fetch_inst_vld, 8'h01);
            check_value("o_fetch_off[0]", o_fetch_off[0], 0);
        end else begin
            check_value("o_fetch_exc", o_fetch_exc, 0);
            // second line needed once the block starts in the upper half
            check_value("o_icache_get2", beat_get2, exp_pc[4]);
            n = 0;
            off = 0;
            // walk the block parcel by parcel
            while (off < size) begin
                w = mem_word(exp_pc + addr_t'(off));
                check_value($sformatf("o_fetch_inst[%0d]", n), o_fetch_inst[n], w);
                check_value($sformatf("o_fetch_off[%0d]", n), o_fetch_off[n], off);
                n++;
                off += (w[1:0] == 2'b11) ? 4 : 2;
            end
            check_value("o_fetch_inst_vld", o_fetch_inst_vld, (1 << n) - 1);
        end
        if (timing_on) begin
            if (req_cycles.size() == 0) begin
                errors++;
                $display("output block at %0t has no granted request behind it", $time);
            end else begin
                check_value("grant_to_output_cycles", cycle - req_cycles.pop_front(), 3);
            end
        end
        seen_idx.push_back(exp_idx);
        seen_start.push_back(exp_pc);
        seen_size.push_back(size);
        exp_pc = exp_pc + size;
        exp_idx = exp_idx + 1'b1;
        blocks_done++;
    endtask

    task automatic sample_outputs();
        if (rd_chk) begin
            check_value("o_read_start", o_read_start, rd_start);
            check_value("o_read_next", o_read_next, rd_next);
        end
        if (prev_squash) begin
            check_value("o_fetch_inst_vld", o_fetch_inst_vld, 0);
        end else if (prev_stall) begin
            // held steady through the stall
            check_value("o_fetch_inst_vld", o_fetch_inst_vld, snap_vld);
            check_value("o_fetch_idx_out", o_fetch_idx_out, snap_idx);
            check_value("o_fetch_exc", o_fetch_exc, snap_exc);
            for (int k = 0; k < FETCH_WIDTH; k++) begin
                check_value($sformatf("o_fetch_inst[%0d]", k), o_fetch_inst[k], snap_inst[k]);
                check_value($sformatf("o_fetch_off[%0d]", k), o_fetch_off[k], snap_off[k]);
            end
        end else if (o_fetch_inst_vld != '0) begin
            check_beat();
        end
        snap_vld = o_fetch_inst_vld;
        snap_idx = o_fetch_idx_out;
        snap_exc = o_fetch_exc;
        snap_inst = o_fetch_inst;
        snap_off = o_fetch_off;
    endtask

    task automatic plan_next();
        logic [31:0] r;
        int          k;

        take_bits(3, r);
        nxt_gnt = gnt_always || (r[2:0] != 0);
        take_bits(4, r);
        nxt_stall = stall_on && !squash_pending && (r[3:0] == 0);
        nxt_squash = squash_pending;
        nxt_squash_pc = squash_target;
        squash_pending = 1'b0;
        nxt_commit_vld = 1'b0;
        if (commit_on && !nxt_squash && seen_idx.size() > 0) begin
            take_bits(2, r);
            if (r[1:0] != 0) begin
                take_bits(3, r);
                k = r[2:0] % seen_idx.size();
                nxt_commit_vld = 1'b1;
                nxt_commit_idx = seen_idx[k];
                commit_next_idx = seen_idx[k] + 1'b1;
                repeat (k + 1) begin
                    void'(seen_idx.pop_front());
                    void'(seen_start.pop_front());
                    void'(seen_size.pop_front());
                end
            end
        end
        rd_chk = 1'b0;
        if (seen_idx.size() > 0) begin
            take_bits(3, r);
            k = r[2:0] % seen_idx.size();
            nxt_read_idx = seen_idx[k];
            rd_chk = 1'b1;
            rd_start = seen_start[k];
            rd_next = seen_start[k] + seen_size[k];
        end
    endtask

    task automatic step();
        @(posedge clk);
        cycle++;
        prev_stall = i_backend_stall;
        prev_squash = i_squash_vld;
        beat_get2 = rsp_get2;
        #2;
        i_icache_gnt = nxt_gnt;
        i_backend_stall = nxt_stall;
        i_squash_vld = nxt_squash;
        i_squash_pc = nxt_squash_pc;
        i_commit_vld = nxt_commit_vld;
        i_commit_idx = nxt_commit_idx;
        i_read_idx = nxt_read_idx;
        i_icache_rsp = d2_vld;
        i_icache_line0 = line_data(d2_addr);
        i_icache_line1 = line_data(d2_addr + 1'b1);
        rsp_get2 = d2_get2;
        @(negedge clk);
        sample_outputs();
        d2_vld = d1_vld;
        d2_addr = d1_addr;
        d2_get2 = d1_get2;
        d1_vld = o_icache_req && i_icache_gnt;
        d1_addr = o_icache_addr;
        d1_get2 = o_icache_get2;
        if (timing_on && d1_vld) begin
            req_cycles.push_back(cycle);
        end
        if (i_squash_vld) begin
            exp_pc = i_squash_pc;
            exp_idx = commit_next_idx;
            seen_idx.delete();
            seen_start.delete();
            seen_size.delete();
        end
        plan_next();
    endtask

    task automatic run_blocks(input int n);
        int target;
        int cyc;

        target = blocks_done + n;
        cyc = 0;
        while (blocks_done < target && cyc < 40 * n + 200) begin
            step();
            cyc++;
        end
        if (blocks_done < target) begin
            abort_run("timeout: fetched blocks stopped arriving");
        end
    endtask

    task automatic do_squash(input addr_t target);
        squash_pending = 1'b1;
        squash_target = target;
        step();
        step();
    endtask

    task automatic random_target(input logic odd, output addr_t t);
        logic [31:0] r;

        take_bits(12, r);
        t = RESET_PC + {r[11:1], odd};
    endtask

    initial begin
        addr_t t;
        int    cyc;

        fill_image();
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        plan_next();

        // plain sequential fetch
        run_blocks(40);

        // random backend stalls
        stall_on = 1'b1;
        run_blocks(60);

        // squashes to aligned and odd targets
        for (int i = 0; i < 6; i++) begin
            random_target(i[0], t);
            do_squash(t);
            run_blocks(12);
        end
        stall_on = 1'b0;

        // withheld commits fill the FTQ and fetch stops
        commit_on = 1'b0;
        cyc = 0;
        while (seen_idx.size() < FTQ_DEPTH && cyc < 400) begin
            step();
            cyc++;
        end
        if (seen_idx.size() < FTQ_DEPTH) begin
            abort_run("timeout: FTQ never filled while commits were withheld");
        end
        repeat (40) step();
        check_value("uncommitted_blocks", seen_idx.size(), FTQ_DEPTH);
        commit_on = 1'b1;
        run_blocks(20);

        // grant always high, request to output latency
        gnt_always = 1'b1;
        random_target(1'b0, t);
        do_squash(t);
        timing_on = 1'b1;
        run_blocks(20);
        timing_on = 1'b0;

        $display("errors: %0d of %0d checks, %0d blocks", errors, checks, blocks_done);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
